// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
SEED      ?= 42959
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee /dev/stderr | \
		grep -x "Test passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_core.sv
`include "core_defines.svh"

module tb_core;

	localparam int PERIOD      = 100;
	localparam int NPROG       = 200;  // the self-loop sits right after the random part.
	localparam int DRAIN_LIMIT = 20000;
	localparam core_pkg::word_t LOOP_PC = `RESET_PC + NPROG * 4;

	logic               clock = 1'b0;
	logic               rst_n = 1'b0;
	logic               inst_valid = 1'b0;
	core_pkg::word_t    inst = '0;
	core_pkg::word_t    inst_pc = '0;
	logic               inst_ready;
	logic               redirect_valid;
	core_pkg::word_t    redirect_pc;
	logic               retire_valid;
	core_pkg::reg_idx_t retire_rd;
	core_pkg::word_t    retire_data;

	core_pkg::word_t    prog [NPROG+1];
	core_pkg::reg_idx_t exp_rd [$];
	core_pkg::word_t    exp_data [$];
	core_pkg::word_t    exp_redir [$];
	core_pkg::word_t    fetch_pc = `RESET_PC;
	logic               took = 1'b0;
	logic               out_of_reset = 1'b0;
	int                 reset_cycles = 0;
	int                 accepted = 0;
	int                 model_count = 0;
	int                 idle_cycles = 0;
	int                 value_errors = 0;
	int                 other_errors = 0;

	core_top DUT (.*);

	initial begin
		forever #(PERIOD / 2) clock = ~clock;
	end

	// ----------------------------------------
	// random program and reference model
	// ----------------------------------------
	task automatic generate_program();
		core_pkg::reg_idx_t last_rd;
		core_pkg::reg_idx_t rd;
		core_pkg::reg_idx_t rs1;
		core_pkg::reg_idx_t rs2;
		logic [20:0]        off;
		core_pkg::word_t    rnd;
		core_pkg::word_t    pick;
		int                 kind;
		int                 dest;

		last_rd = '0;
		for (int i = 0; i < NPROG; i++) begin
			kind = int'($urandom_range(99));
			pick = $urandom();
			rnd  = $urandom();
			rd   = {1'b0, pick[2:0]};                      // short chains over x0..x7.
			rs1  = (pick[5:3] < 3'd5) ? last_rd : pick[9:6];
			rs2  = (pick[11:10] == 2'd0) ? rs1 : pick[15:12];
			dest = i + 1 + int'($urandom_range(4));        // control transfers only go forward.
			if (dest > NPROG) begin
				dest = NPROG;
			end
			off = 21'((dest - i) * 4);
			if (kind < 35) begin
				prog[i] = {rnd[11:0], 1'b0, rs1, 3'b000, 1'b0, rd, `OPC_OPIMM, 2'b11};
			end else if (kind < 60) begin
				prog[i] = {1'b0, rnd[0], 5'b0, 1'b0, rs2, 1'b0, rs1, 3'b000,
					1'b0, rd, `OPC_OP, 2'b11};
			end else if (kind < 67) begin
				prog[i] = {rnd[31:12], 1'b0, rd, `OPC_LUI, 2'b11};
			end else if (kind < 73) begin
				prog[i] = {rnd[31:12], 1'b0, rd, `OPC_AUIPC, 2'b11};
			end else if (kind < 88) begin
				prog[i] = {off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, 2'b00, rnd[0],
					off[4:1], off[11], `OPC_BRANCH, 2'b11};
			end else if (kind < 94) begin
				prog[i] = {off[20], off[10:1], off[11], off[19:12],
					1'b0, rd, `OPC_JAL, 2'b11};
			end else begin
				prog[i] = {12'(`RESET_PC + dest * 4), 1'b0, 4'h0, 3'b000,
					1'b0, rd, `OPC_JALR, 2'b11};
			end
			last_rd = rd;
		end
		prog[NPROG] = {20'h0, 5'h0, `OPC_JAL, 2'b11};  // jal x0, 0.
	endtask

	task automatic run_model();
		core_pkg::word_t regs [16];
		core_pkg::word_t pc;
		core_pkg::word_t w;
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t imm_i;
		core_pkg::word_t result;
		core_pkg::word_t next_pc;
		logic            writes;
		logic            jump;

		for (int r = 0; r < 16; r++) begin
			regs[r] = '0;
		end
		pc = `RESET_PC;
		while (pc != LOOP_PC && model_count <= NPROG) begin
			w       = prog[(pc - `RESET_PC) >> 2];
			a       = regs[w[18:15]];
			b       = regs[w[23:20]];
			imm_i   = {{20{w[31]}}, w[31:20]};
			result  = pc + 4;                              // link value of both jumps.
			next_pc = pc + 4;
			writes  = 1'b1;
			jump    = 1'b0;
			case (w[6:2])
				`OPC_LUI:   result = {w[31:12], 12'b0};
				`OPC_AUIPC: result = pc + {w[31:12], 12'b0};
				`OPC_OPIMM: result = a + imm_i;
				`OPC_OP:    result = w[30] ? a - b : a + b;
				`OPC_JAL: begin
					jump    = 1'b1;
					next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				`OPC_JALR: begin
					jump    = 1'b1;
					next_pc = (a + imm_i) & ~32'd1;
				end
				`OPC_BRANCH: begin
					writes = 1'b0;
					jump   = (a == b) ^ w[12];                 // funct3 bit 0 turns beq into bne.
					if (jump) begin
						next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
					end
				end
				default: writes = 1'b0;
			endcase
			if (writes && w[10:7] != 4'h0) begin
				regs[w[10:7]] = result;
				exp_rd.push_back(w[10:7]);
				exp_data.push_back(result);
			end
			if (jump) begin
				exp_redir.push_back(next_pc);
			end
			pc = next_pc;
			model_count++;
		end
	endtask

	// ----------------------------------------
	// fetcher and output checks
	// ----------------------------------------
	always @(negedge clock) begin
		if (!rst_n) begin
			reset_cycles++;
			rst_n = (reset_cycles == 8);
		end else begin
			if (took) begin
				assert (accepted > 0 || inst_pc == `RESET_PC) else begin
					$display("first accepted instruction is at %h, not at the reset pc", inst_pc);
					other_errors++;
				end
				accepted++;
				idle_cycles = 0;
				fetch_pc = fetch_pc + 4;
			end else begin
				idle_cycles++;
			end
			if (retire_valid) begin
				assert (retire_rd != 4'h0) else begin
					$display("a write to x0 showed up on the retire port");
					other_errors++;
				end
				assert (exp_rd.size() > 0) else begin
					$display("retire of x%0d with no result left in the model", retire_rd);
					other_errors++;
				end
				if (exp_rd.size() > 0) begin
					assert (retire_rd == exp_rd[0]) else begin
						$display("FAILED retire_rd: got %h, expected %h", retire_rd, exp_rd[0]);
						value_errors++;
					end
					assert (retire_data == exp_data[0]) else begin
						$display("FAILED retire_data: got %h, expected %h",
							retire_data, exp_data[0]);
						value_errors++;
					end
					void'(exp_rd.pop_front());
					void'(exp_data.pop_front());
				end
			end
			if (redirect_valid) begin
				assert (exp_redir.size() > 0) else begin
					$display("redirect to %h while the model expects none", redirect_pc);
					other_errors++;
				end
				if (exp_redir.size() > 0) begin
					assert (redirect_pc == exp_redir[0]) else begin
						$display("FAILED redirect_pc: got %h, expected %h",
							redirect_pc, exp_redir[0]);
						value_errors++;
					end
					void'(exp_redir.pop_front());
				end
				fetch_pc = redirect_pc;
			end
		end
		if (rst_n && (fetch_pc - `RESET_PC) < NPROG * 4) begin
			inst_valid = 1'b1;
			inst       = prog[(fetch_pc - `RESET_PC) >> 2];
			inst_pc    = fetch_pc;
		end else begin
			inst_valid = 1'b0;                               // never fetch the self-loop.
		end
	end

	always @(posedge clock) begin
		took <= rst_n & inst_valid & inst_ready;
		if (reset_cycles > 0 && !out_of_reset) begin
			assert (!inst_ready && !redirect_valid && !retire_valid) else begin
				$display("core is not idle during reset or on the first edge after it");
				other_errors++;
			end
			out_of_reset <= rst_n;
		end
	end

	initial begin
		int waited;

		void'($urandom(42959));
		generate_program();
		run_model();
		waited = 0;
		while (!(fetch_pc == LOOP_PC && idle_cycles >= 3 && exp_rd.size() == 0 &&
			exp_redir.size() == 0) && waited < DRAIN_LIMIT) begin
			@(posedge clock);
			waited++;
		end
		if (waited >= DRAIN_LIMIT) begin
			$display("timeout after %0d cycles, the core did not finish the program", waited);
			other_errors++;
		end
		assert (accepted == model_count) else begin
			$display("core accepted %0d instructions, the model executed %0d",
				accepted, model_count);
			other_errors++;
		end
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: common/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ----------------------------------------
// register file
// ----------------------------------------
`define CORE_NREGS 16

// bit positions inside the one-hot op vector.
`define OP_IDX_LUI    0
`define OP_IDX_AUIPC  1
`define OP_IDX_JAL    2
`define OP_IDX_JALR   3
`define OP_IDX_BRANCH 4
`define OP_IDX_ADDI   5
`define OP_IDX_ADD    6

// ----------------------------------------
// opcode field, instruction bits 6:2
// ----------------------------------------
`define OPC_LUI    5'b01101
`define OPC_AUIPC  5'b00101
`define OPC_JAL    5'b11011
`define OPC_JALR   5'b11001
`define OPC_BRANCH 5'b11000
`define OPC_OPIMM  5'b00100
`define OPC_OP     5'b01100

`define RESET_PC 32'h0000_0000

`endif

// File: common/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

	// ----------------------------------------
	// data and index types
	// ----------------------------------------
	typedef logic [31:0] word_t;

	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t; // 4 bits for RV32E.

	// one bit per instruction kind, see OP_IDX_* for positions.
	typedef logic [`OP_IDX_ADD:0] op_vec_t;

	// ----------------------------------------
	// control state
	// ----------------------------------------
	typedef enum logic {
		RUN      = 1'b0,
		REDIRECT = 1'b1
	} ctrl_state_e;

endpackage

// File: common/uop_if.sv
// decoded instruction travelling from decode to execute.
interface uop_if;
	logic               valid;
	core_pkg::word_t    pc;
	core_pkg::op_vec_t  op;
	logic [2:0]         funct3;
	logic               funct7_5;  // selects sub for the register form.
	core_pkg::reg_idx_t rd;
	logic               reg_wen;
	core_pkg::word_t    src1;      // operands are already resolved in decode.
	core_pkg::word_t    src2;
	core_pkg::word_t    imm;

	modport producer (
		output valid, pc, op, funct3, funct7_5, rd, reg_wen, src1, src2, imm
	);

	modport consumer (
		input valid, pc, op, funct3, funct7_5, rd, reg_wen, src1, src2, imm
	);
endinterface

// File: common/wb_if.sv
// write-back result, one register write per cycle at most.
interface wb_if;
	logic               valid;
	core_pkg::reg_idx_t rd;
	core_pkg::word_t    data;

	modport source (
		output valid, rd, data
	);

	modport sink (
		input valid, rd, data
	);
endinterface

// File: decode/decode_stage.sv
`include "core_defines.svh"

module decode_stage (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               inst_valid,
	input  core_pkg::word_t    inst,
	input  core_pkg::word_t    inst_pc,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	output logic               need_rs1,
	output logic               need_rs2,
	input  core_pkg::word_t    rdata1,
	input  core_pkg::word_t    rdata2,
	input  logic               stall,
	input  logic               flush,
	input  logic               fwd1,
	input  logic               fwd2,
	wb_if.sink                 wb,
	uop_if.producer            uop
);

	logic [4:0]         opcode;
	core_pkg::op_vec_t  op;
	core_pkg::reg_idx_t rd;
	logic               reg_wen;
	logic               accept;
	core_pkg::word_t    imm;
	core_pkg::word_t    imm_i;
	core_pkg::word_t    imm_b;
	core_pkg::word_t    imm_u;
	core_pkg::word_t    imm_j;
	core_pkg::word_t    src1;
	core_pkg::word_t    src2;

	// ----------------------------------------
	// field extraction
	// ----------------------------------------
	assign opcode = inst[6:2];
	assign rd     = inst[10:7];   // RV32E only has 16 registers, bit 11 is dropped.
	assign rs1    = inst[18:15];
	assign rs2    = inst[23:20];

	assign op[`OP_IDX_LUI]    = (opcode == `OPC_LUI);
	assign op[`OP_IDX_AUIPC]  = (opcode == `OPC_AUIPC);
	assign op[`OP_IDX_JAL]    = (opcode == `OPC_JAL);
	assign op[`OP_IDX_JALR]   = (opcode == `OPC_JALR);
	assign op[`OP_IDX_BRANCH] = (opcode == `OPC_BRANCH);
	assign op[`OP_IDX_ADDI]   = (opcode == `OPC_OPIMM);  // every funct3 is treated as addi.
	assign op[`OP_IDX_ADD]    = (opcode == `OPC_OP);

	assign need_rs2 = op[`OP_IDX_BRANCH] | op[`OP_IDX_ADD];
	assign need_rs1 = need_rs2 | op[`OP_IDX_JALR] | op[`OP_IDX_ADDI];
	assign reg_wen  = ~op[`OP_IDX_BRANCH] & (|op);

	// ----------------------------------------
	// immediates
	// ----------------------------------------
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		imm = imm_i;
		if (op[`OP_IDX_LUI] | op[`OP_IDX_AUIPC]) begin
			imm = imm_u;
		end else if (op[`OP_IDX_JAL]) begin
			imm = imm_j;
		end else if (op[`OP_IDX_BRANCH]) begin
			imm = imm_b;
		end
	end

	// the write-back value is not in the register file until the next edge.
	assign src1 = fwd1 ? wb.data : rdata1;
	assign src2 = fwd2 ? wb.data : rdata2;

	assign accept = inst_valid & ~stall & ~flush;

	// ----------------------------------------
	// uop register
	// ----------------------------------------
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			uop.valid <= 1'b0;
		end else begin
			uop.valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			uop.pc       <= inst_pc;
			uop.op       <= op;
			uop.funct3   <= inst[14:12];
			uop.funct7_5 <= inst[30];
			uop.rd       <= rd;
			uop.reg_wen  <= reg_wen;
			uop.src1     <= src1;
			uop.src2     <= src2;
			uop.imm      <= imm;
		end
	end

	a_op_onehot: assert property (@(posedge clock) disable iff (!rst_n)
		uop.valid |-> $onehot0(uop.op));

endmodule

// File: decode/pipe_ctrl.sv
module pipe_ctrl (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               inst_valid,
	output logic               inst_ready,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	input  logic               need_rs1,
	input  logic               need_rs2,
	uop_if.consumer            uop,
	wb_if.sink                 wb,
	input  logic               taken,
	input  core_pkg::word_t    target,
	output logic               stall,
	output logic               flush,
	output logic               fwd1,
	output logic               fwd2,
	output logic               redirect_valid,
	output core_pkg::word_t    redirect_pc
);

	core_pkg::ctrl_state_e state;
	logic                  exu_writes;
	logic                  raw_hazard;

	// ----------------------------------------
	// hazards and forwarding
	// ----------------------------------------
	assign exu_writes = uop.valid & uop.reg_wen & (uop.rd != '0);

	// execute result is one cycle away, wait for it to reach write-back.
	assign raw_hazard = inst_valid & exu_writes &
		(need_rs1 & (rs1 != '0) & (rs1 == uop.rd) |
		 need_rs2 & (rs2 != '0) & (rs2 == uop.rd));

	assign fwd1 = wb.valid & need_rs1 & (rs1 != '0) & (rs1 == wb.rd);
	assign fwd2 = wb.valid & need_rs2 & (rs2 != '0) & (rs2 == wb.rd);

	assign flush      = taken;
	assign stall      = raw_hazard | (state == core_pkg::REDIRECT);
	assign inst_ready = ~stall & ~flush;

	// ----------------------------------------
	// redirect sequencing
	// ----------------------------------------
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state          <= core_pkg::REDIRECT;  // keeps fetch closed for the first cycle.
			redirect_valid <= 1'b0;
		end else if (flush) begin
			state          <= core_pkg::REDIRECT;
			redirect_valid <= 1'b1;
		end else begin
			state          <= core_pkg::RUN;
			redirect_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (flush) begin
			redirect_pc <= target;
		end
	end

	a_redirect_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		redirect_valid |=> !redirect_valid);

	// decode must take nothing while fetch is closed.
	a_closed_in_redirect: assert property (@(posedge clock) disable iff (!rst_n)
		(state == core_pkg::REDIRECT) |=> !uop.valid);

endmodule

// File: list.f
+incdir+common
common/core_pkg.sv
common/uop_if.sv
common/wb_if.sv
decode/decode_stage.sv
decode/pipe_ctrl.sv
rtl/regfile.sv
rtl/exec_stage.sv
rtl/core_top.sv
bench/tb_core.sv

// File: rtl/core_top.sv
module core_top (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               inst_valid,
	output logic               inst_ready,
	input  core_pkg::word_t    inst,
	input  core_pkg::word_t    inst_pc,
	output logic               redirect_valid,
	output core_pkg::word_t    redirect_pc,
	output logic               retire_valid,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_data
);

	core_pkg::reg_idx_t rs1;
	core_pkg::reg_idx_t rs2;
	logic               need_rs1;
	logic               need_rs2;
	core_pkg::word_t    rdata1;
	core_pkg::word_t    rdata2;
	logic               stall;
	logic               flush;
	logic               fwd1;
	logic               fwd2;
	logic               taken;
	core_pkg::word_t    target;

	uop_if uop ();
	wb_if  wb ();

	decode_stage u_decode (
		.clock      (clock),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.rs1        (rs1),
		.rs2        (rs2),
		.need_rs1   (need_rs1),
		.need_rs2   (need_rs2),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.stall      (stall),
		.flush      (flush),
		.fwd1       (fwd1),
		.fwd2       (fwd2),
		.wb         (wb.sink),
		.uop        (uop.producer)
	);

	pipe_ctrl u_ctrl (
		.clock          (clock),
		.rst_n          (rst_n),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.rs1            (rs1),
		.rs2            (rs2),
		.need_rs1       (need_rs1),
		.need_rs2       (need_rs2),
		.uop            (uop.consumer),
		.wb             (wb.sink),
		.taken          (taken),
		.target         (target),
		.stall          (stall),
		.flush          (flush),
		.fwd1           (fwd1),
		.fwd2           (fwd2),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	regfile u_regfile (
		.clock  (clock),
		.rst_n  (rst_n),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wb     (wb.sink)
	);

	exec_stage u_exec (
		.clock  (clock),
		.rst_n  (rst_n),
		.uop    (uop.consumer),
		.taken  (taken),
		.target (target),
		.wb     (wb.source)
	);

	// retire port is the write-back bundle itself.
	assign retire_valid = wb.valid;
	assign retire_rd    = wb.rd;
	assign retire_data  = wb.data;

endmodule

// File: rtl/exec_stage.sv
`include "core_defines.svh"

module exec_stage (
	input  logic            clock,
	input  logic            rst_n,
	uop_if.consumer         uop,
	output logic            taken,
	output core_pkg::word_t target,
	wb_if.source            wb
);

	core_pkg::word_t result;
	core_pkg::word_t link;
	core_pkg::word_t jalr_sum;
	logic            src_eq;
	logic            branch_true;

	// ----------------------------------------
	// ALU
	// ----------------------------------------
	assign link = uop.pc + 32'd4;

	always_comb begin
		result = uop.src1 + uop.imm;  // addi.
		if (uop.op[`OP_IDX_LUI]) begin
			result = uop.imm;
		end else if (uop.op[`OP_IDX_AUIPC]) begin
			result = uop.pc + uop.imm;
		end else if (uop.op[`OP_IDX_JAL] | uop.op[`OP_IDX_JALR]) begin
			result = link;
		end else if (uop.op[`OP_IDX_ADD]) begin
			result = uop.funct7_5 ? (uop.src1 - uop.src2) : (uop.src1 + uop.src2);
		end
	end

	// ----------------------------------------
	// control transfer
	// ----------------------------------------
	assign src_eq      = (uop.src1 == uop.src2);
	assign branch_true = uop.funct3[0] ? ~src_eq : src_eq;  // bne when bit 0 is set.
	assign jalr_sum    = uop.src1 + uop.imm;

	assign taken = uop.valid & (uop.op[`OP_IDX_JAL] | uop.op[`OP_IDX_JALR] |
		uop.op[`OP_IDX_BRANCH] & branch_true);

	assign target = uop.op[`OP_IDX_JALR] ? {jalr_sum[31:1], 1'b0} : (uop.pc + uop.imm);

	// ----------------------------------------
	// write-back register
	// ----------------------------------------
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= uop.valid & uop.reg_wen & (uop.rd != '0);
		end
	end

	always_ff @(posedge clock) begin
		wb.rd   <= uop.rd;
		wb.data <= result;
	end

	// the wrong-path slot behind a control transfer stays empty.
	a_taken_flush: assert property (@(posedge clock) disable iff (!rst_n)
		taken |=> !uop.valid);

endmodule

// File: rtl/regfile.sv
`include "core_defines.svh"

module regfile (
	input  logic               clock,
	input  logic               rst_n,
	input  core_pkg::reg_idx_t raddr1,
	input  core_pkg::reg_idx_t raddr2,
	output core_pkg::word_t    rdata1,
	output core_pkg::word_t    rdata2,
	wb_if.sink                 wb
);

	core_pkg::word_t regs [`CORE_NREGS];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// x0 reads zero whatever the array holds.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule
